/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_xbar -o sim_xbar
	./obj_dir/sim_xbar | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/xbar_macros.svh */
`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

// Port counts of the crossbar
`define XBAR_NO_SLV_PORTS 2
`define XBAR_NO_MST_PORTS 3

// Entries in the global address map
`define XBAR_NO_ADDR_RULES 4

// Bus widths
`define XBAR_ADDR_WIDTH 32
`define XBAR_DATA_WIDTH 32

// Register cuts on every connected lane
`define XBAR_PIPE_STAGES 1

// Outstanding transactions per direction and slave port
`define XBAR_MAX_TRANS 4

// One row per slave port, bit j set when master j is reachable
// Slave 1 has no path to master 2
`define XBAR_CONNECTIVITY 6'b011_111

`endif

/* source/addr_decoder.sv */
`timescale 1ns/1ps
`include "xbar_macros.svh"

module addr_decoder (
  input  xbar_pkg::addr_t                          addr_i,
  input  xbar_pkg::rule_t [`XBAR_NO_ADDR_RULES-1:0] addr_map_i,
  input  logic                                     en_default_i,
  input  xbar_pkg::mst_idx_t                       default_idx_i,
  output xbar_pkg::sel_t                           sel_o
);

  import xbar_pkg::*;

  // Set once a rule has claimed the address
  logic hit;

  always_comb begin
    hit = 1'b0;
    // Fallback when nothing matches
    if (en_default_i) begin
      sel_o = sel_t'(default_idx_i);
    end else begin
      sel_o = SEL_DECERR;
    end

    // Lowest rule number wins on overlap
    for (int unsigned r = 0; r < `XBAR_NO_ADDR_RULES; r++) begin
      if (!hit &&
          (addr_i >= addr_map_i[r].start_addr) &&
          (addr_i <  addr_map_i[r].end_addr)) begin
        hit   = 1'b1;
        // A rule pointing at index 3 lands on the error lane as well
        sel_o = sel_t'(addr_map_i[r].idx);
      end
    end
  end

endmodule

/* source/chan_cut.sv */
`timescale 1ns/1ps
`include "xbar_macros.svh"

module chan_cut #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  localparam int unsigned Stages = `XBAR_PIPE_STAGES;

  // Stage s sits between node s and node s+1
  logic     valid [Stages+1];
  logic     ready [Stages+1];
  payload_t data  [Stages+1];

  assign valid[0]      = valid_i;
  assign ready_o       = ready[0];
  assign data[0]       = data_i;
  assign valid_o       = valid[Stages];
  assign ready[Stages] = ready_i;
  assign data_o        = data[Stages];

  for (genvar s = 0; s < Stages; s++) begin : gen_stage
    // Output register and the skid entry behind it
    logic     main_valid_q;
    logic     skid_valid_q;
    payload_t main_q;
    payload_t skid_q;
    logic     main_load;

    // Output register free or drained this cycle
    assign main_load = ~main_valid_q | ready[s+1];

    // Ready is registered, low only with both entries full
    assign ready[s]   = ~skid_valid_q;
    assign valid[s+1] = main_valid_q;
    assign data[s+1]  = main_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        main_valid_q <= 1'b0;
        skid_valid_q <= 1'b0;
      end else if (main_load) begin
        // Skid entry goes first, the input waits
        main_valid_q <= skid_valid_q | valid[s];
        skid_valid_q <= 1'b0;
      end else if (valid[s] && !skid_valid_q) begin
        // Output stalled, park the new beat
        skid_valid_q <= 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (main_load) begin
        main_q <= skid_valid_q ? skid_q : data[s];
      end
      if (!main_load && !skid_valid_q) begin
        skid_q <= data[s];
      end
    end
  end

endmodule

/* source/decerr_responder.sv */
`timescale 1ns/1ps

module decerr_responder (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  xbar_pkg::lite_req_t req_i,
  output xbar_pkg::lite_rsp_t rsp_o
);

  import xbar_pkg::*;

  // One pending response per direction
  logic b_pend_q;
  logic r_pend_q;

  logic w_take;
  logic r_take;

  // AW and W arrive together from the demux
  assign w_take = req_i.aw_valid & req_i.w_valid & ~b_pend_q;
  assign r_take = req_i.ar_valid & ~r_pend_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (w_take) begin
        b_pend_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_pend_q <= 1'b0;
      end

      if (r_take) begin
        r_pend_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rsp_o = '0;
    // Ready only while nothing waits, independent of valid
    rsp_o.aw_ready = ~b_pend_q;
    rsp_o.w_ready  = ~b_pend_q;
    rsp_o.ar_ready = ~r_pend_q;

    rsp_o.b.resp   = RESP_DECERR;
    rsp_o.b_valid  = b_pend_q;

    // Read data is zero
    rsp_o.r.data   = '0;
    rsp_o.r.resp   = RESP_DECERR;
    rsp_o.r_valid  = r_pend_q;
  end

endmodule

/* source/lane_cut.sv */
`timescale 1ns/1ps

module lane_cut (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  xbar_pkg::lite_req_t slv_req_i,
  output xbar_pkg::lite_rsp_t slv_rsp_o,
  output xbar_pkg::lite_req_t mst_req_o,
  input  xbar_pkg::lite_rsp_t mst_rsp_i
);

  import xbar_pkg::*;

  // Write address, forward
  chan_cut #(.payload_t(aw_chan_t)) i_aw_cut (
    .clk_i, .arst_n_i,
    .valid_i (slv_req_i.aw_valid), .ready_o (slv_rsp_o.aw_ready), .data_i (slv_req_i.aw),
    .valid_o (mst_req_o.aw_valid), .ready_i (mst_rsp_i.aw_ready), .data_o (mst_req_o.aw)
  );

  // Write data, forward
  chan_cut #(.payload_t(w_chan_t)) i_w_cut (
    .clk_i, .arst_n_i,
    .valid_i (slv_req_i.w_valid), .ready_o (slv_rsp_o.w_ready), .data_i (slv_req_i.w),
    .valid_o (mst_req_o.w_valid), .ready_i (mst_rsp_i.w_ready), .data_o (mst_req_o.w)
  );

  // Write response, backward
  chan_cut #(.payload_t(b_chan_t)) i_b_cut (
    .clk_i, .arst_n_i,
    .valid_i (mst_rsp_i.b_valid), .ready_o (mst_req_o.b_ready), .data_i (mst_rsp_i.b),
    .valid_o (slv_rsp_o.b_valid), .ready_i (slv_req_i.b_ready), .data_o (slv_rsp_o.b)
  );

  // Read address, forward
  chan_cut #(.payload_t(ar_chan_t)) i_ar_cut (
    .clk_i, .arst_n_i,
    .valid_i (slv_req_i.ar_valid), .ready_o (slv_rsp_o.ar_ready), .data_i (slv_req_i.ar),
    .valid_o (mst_req_o.ar_valid), .ready_i (mst_rsp_i.ar_ready), .data_o (mst_req_o.ar)
  );

  // Read data, backward
  chan_cut #(.payload_t(r_chan_t)) i_r_cut (
    .clk_i, .arst_n_i,
    .valid_i (mst_rsp_i.r_valid), .ready_o (mst_req_o.r_ready), .data_i (mst_rsp_i.r),
    .valid_o (slv_rsp_o.r_valid), .ready_i (slv_req_i.r_ready), .data_o (slv_rsp_o.r)
  );

endmodule

/* source/lite_demux.sv */
`timescale 1ns/1ps
`include "xbar_macros.svh"

module lite_demux (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  xbar_pkg::lite_req_t                         slv_req_i,
  output xbar_pkg::lite_rsp_t                         slv_rsp_o,
  input  xbar_pkg::sel_t                              aw_sel_i,
  input  xbar_pkg::sel_t                              ar_sel_i,
  output xbar_pkg::lite_req_t [`XBAR_NO_MST_PORTS:0]  lane_req_o,
  input  xbar_pkg::lite_rsp_t [`XBAR_NO_MST_PORTS:0]  lane_rsp_i
);

  import xbar_pkg::*;

  // Master lanes plus the error lane
  localparam int unsigned NoLanes  = `XBAR_NO_MST_PORTS + 1;
  localparam int unsigned CntWidth = $clog2(`XBAR_MAX_TRANS + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  localparam cnt_t MaxCnt = cnt_t'(`XBAR_MAX_TRANS);

  // Lane of the transactions in flight, per direction
  sel_t w_tgt_q;
  sel_t r_tgt_q;
  cnt_t w_cnt_q;
  cnt_t r_cnt_q;

  logic w_free;
  logic r_free;
  logic w_go;
  logic r_go;
  logic aw_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  // Idle, or same target with room left
  assign w_free = (w_cnt_q == '0) || ((aw_sel_i == w_tgt_q) && (w_cnt_q != MaxCnt));
  assign r_free = (r_cnt_q == '0) || ((ar_sel_i == r_tgt_q) && (r_cnt_q != MaxCnt));

  // Write only moves with AW and W together
  assign w_go = w_free && slv_req_i.aw_valid && slv_req_i.w_valid;
  assign r_go = r_free && slv_req_i.ar_valid;

  always_comb begin
    lane_req_o = '0;
    slv_rsp_o  = '0;

    // Payloads fan out to every lane, valid picks the one that counts
    for (int unsigned l = 0; l < NoLanes; l++) begin
      lane_req_o[l].aw = slv_req_i.aw;
      lane_req_o[l].w  = slv_req_i.w;
      lane_req_o[l].ar = slv_req_i.ar;
    end

    // Each valid waits on the sibling ready so AW and W leave in the same cycle
    // Lane readies never look at valid, so this has no loop
    lane_req_o[aw_sel_i].aw_valid = w_go & lane_rsp_i[aw_sel_i].w_ready;
    lane_req_o[aw_sel_i].w_valid  = w_go & lane_rsp_i[aw_sel_i].aw_ready;
    lane_req_o[ar_sel_i].ar_valid = r_go;

    slv_rsp_o.aw_ready = w_go & lane_rsp_i[aw_sel_i].aw_ready & lane_rsp_i[aw_sel_i].w_ready;
    slv_rsp_o.w_ready  = w_go & lane_rsp_i[aw_sel_i].aw_ready & lane_rsp_i[aw_sel_i].w_ready;
    slv_rsp_o.ar_ready = r_go & lane_rsp_i[ar_sel_i].ar_ready;

    // Responses only from the held target
    lane_req_o[w_tgt_q].b_ready = slv_req_i.b_ready & (w_cnt_q != '0);
    lane_req_o[r_tgt_q].r_ready = slv_req_i.r_ready & (r_cnt_q != '0);

    slv_rsp_o.b       = lane_rsp_i[w_tgt_q].b;
    slv_rsp_o.b_valid = lane_rsp_i[w_tgt_q].b_valid & (w_cnt_q != '0);
    slv_rsp_o.r       = lane_rsp_i[r_tgt_q].r;
    slv_rsp_o.r_valid = lane_rsp_i[r_tgt_q].r_valid & (r_cnt_q != '0);
  end

  // Handshakes seen at the slave port
  assign aw_hs = slv_rsp_o.aw_ready;
  assign ar_hs = slv_rsp_o.ar_ready;
  assign b_hs  = slv_rsp_o.b_valid & slv_req_i.b_ready;
  assign r_hs  = slv_rsp_o.r_valid & slv_req_i.r_ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_tgt_q <= '0;
      r_tgt_q <= '0;
      w_cnt_q <= '0;
      r_cnt_q <= '0;
    end else begin
      if (aw_hs) begin
        w_tgt_q <= aw_sel_i;
      end
      if (ar_hs) begin
        r_tgt_q <= ar_sel_i;
      end

      // Outstanding writes
      case ({aw_hs, b_hs})
        2'b10:   w_cnt_q <= w_cnt_q + cnt_t'(1);
        2'b01:   w_cnt_q <= w_cnt_q - cnt_t'(1);
        default: w_cnt_q <= w_cnt_q;
      endcase

      // Outstanding reads
      case ({ar_hs, r_hs})
        2'b10:   r_cnt_q <= r_cnt_q + cnt_t'(1);
        2'b01:   r_cnt_q <= r_cnt_q - cnt_t'(1);
        default: r_cnt_q <= r_cnt_q;
      endcase
    end
  end

endmodule

/* source/xbar_pkg.sv */
`include "xbar_macros.svh"

package xbar_pkg;

  // Basic payload fields
  typedef logic [`XBAR_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`XBAR_DATA_WIDTH-1:0]   data_t;
  typedef logic [`XBAR_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [1:0]                    resp_t;

  // Response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // Master port index, and index plus the error target
  typedef logic [1:0] mst_idx_t;
  typedef logic [1:0] sel_t;

  // Lane that feeds the decode-error responder
  localparam sel_t SEL_DECERR = sel_t'(`XBAR_NO_MST_PORTS);

  // AXI4-Lite channels
  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

  // Request bundle, manager to subordinate
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  // Response bundle, subordinate to manager
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } lite_rsp_t;

  // Address rule, matches start_addr <= addr < end_addr
  typedef struct packed {
    mst_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

endpackage

/* source/xbar_unmuxed.sv */
`timescale 1ns/1ps
`include "xbar_macros.svh"

module xbar_unmuxed #(
  parameter bit [`XBAR_NO_SLV_PORTS-1:0][`XBAR_NO_MST_PORTS-1:0] Connectivity =
      `XBAR_CONNECTIVITY
) (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  xbar_pkg::lite_req_t [`XBAR_NO_SLV_PORTS-1:0]            slv_req_i,
  output xbar_pkg::lite_rsp_t [`XBAR_NO_SLV_PORTS-1:0]            slv_rsp_o,
  output xbar_pkg::lite_req_t [`XBAR_NO_MST_PORTS-1:0][`XBAR_NO_SLV_PORTS-1:0] mst_req_o,
  input  xbar_pkg::lite_rsp_t [`XBAR_NO_MST_PORTS-1:0][`XBAR_NO_SLV_PORTS-1:0] mst_rsp_i,
  input  xbar_pkg::rule_t     [`XBAR_NO_ADDR_RULES-1:0]           addr_map_i,
  input  logic                [`XBAR_NO_SLV_PORTS-1:0]            en_default_mst_i,
  input  xbar_pkg::mst_idx_t  [`XBAR_NO_SLV_PORTS-1:0]            default_mst_i
);

  import xbar_pkg::*;

  localparam int unsigned NoSlv = `XBAR_NO_SLV_PORTS;
  localparam int unsigned NoMst = `XBAR_NO_MST_PORTS;

  // Demux lanes, last index is the error lane
  lite_req_t [NoSlv-1:0][NoMst:0] lane_req;
  lite_rsp_t [NoSlv-1:0][NoMst:0] lane_rsp;

  for (genvar i = 0; i < NoSlv; i++) begin : gen_slv_port
    sel_t aw_sel;
    sel_t ar_sel;

    // Separate decoders, AW and AR may target different ports
    addr_decoder i_aw_dec (
      .addr_i        (slv_req_i[i].aw.addr),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_mst_i[i]),
      .default_idx_i (default_mst_i[i]),
      .sel_o         (aw_sel)
    );

    addr_decoder i_ar_dec (
      .addr_i        (slv_req_i[i].ar.addr),
      .addr_map_i    (addr_map_i),
      .en_default_i  (en_default_mst_i[i]),
      .default_idx_i (default_mst_i[i]),
      .sel_o         (ar_sel)
    );

    lite_demux i_demux (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .slv_req_i  (slv_req_i[i]),
      .slv_rsp_o  (slv_rsp_o[i]),
      .aw_sel_i   (aw_sel),
      .ar_sel_i   (ar_sel),
      .lane_req_o (lane_req[i]),
      .lane_rsp_i (lane_rsp[i])
    );

    // Unmapped addresses end here
    decerr_responder i_decerr (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (lane_req[i][NoMst]),
      .rsp_o    (lane_rsp[i][NoMst])
    );
  end

  // Lane matrix, master j sees one lane per slave i
  for (genvar i = 0; i < NoSlv; i++) begin : gen_cross_slv
    for (genvar j = 0; j < NoMst; j++) begin : gen_cross_mst
      if (Connectivity[i][j]) begin : gen_connected
        lane_cut i_lane_cut (
          .clk_i     (clk_i),
          .arst_n_i  (arst_n_i),
          .slv_req_i (lane_req[i][j]),
          .slv_rsp_o (lane_rsp[i][j]),
          .mst_req_o (mst_req_o[j][i]),
          .mst_rsp_i (mst_rsp_i[j][i])
        );
      end else begin : gen_disconnected
        // No path, master side stays idle
        assign mst_req_o[j][i] = '0;

        // Local answer so the slave is not left hanging
        decerr_responder i_decerr (
          .clk_i    (clk_i),
          .arst_n_i (arst_n_i),
          .req_i    (lane_req[i][j]),
          .rsp_o    (lane_rsp[i][j])
        );
      end
    end
  end

endmodule

/* tb.f */
+incdir+include
source/xbar_pkg.sv
source/addr_decoder.sv
source/lite_demux.sv
source/decerr_responder.sv
source/chan_cut.sv
source/lane_cut.sv
source/xbar_unmuxed.sv
test/tb_xbar.sv

/* test/tb_xbar.sv */
`timescale 1ns/1ps
`include "xbar_macros.svh"

module tb_xbar;

  import xbar_pkg::*;

  localparam int no_slv  = `XBAR_NO_SLV_PORTS;
  localparam int no_mst  = `XBAR_NO_MST_PORTS;
  localparam int max_vec = 64;

  logic clk_i;
  logic arst_n_i;

  lite_req_t [no_slv-1:0]             slv_req;
  lite_rsp_t [no_slv-1:0]             slv_rsp;
  lite_req_t [no_mst-1:0][no_slv-1:0] mst_req;
  lite_rsp_t [no_mst-1:0][no_slv-1:0] mst_rsp;
  rule_t     [`XBAR_NO_ADDR_RULES-1:0] addr_map;
  logic      [no_slv-1:0]             en_default;
  mst_idx_t  [no_slv-1:0]             default_mst;

  // Vector table, one entry per data line of the file
  int          vec_port  [max_vec];
  int          vec_op    [max_vec];
  logic [31:0] vec_addr  [max_vec];
  logic [31:0] vec_wdata [max_vec];
  int          vec_lane  [max_vec];
  int          vec_resp  [max_vec];
  logic [31:0] vec_rdata [max_vec];
  int          n_vec;

  // Per slave port: issue order, then write and read response order
  int port_list [no_slv][max_vec];
  int port_cnt  [no_slv];
  int wr_list   [no_slv][max_vec];
  int wr_cnt    [no_slv];
  int rd_list   [no_slv][max_vec];
  int rd_cnt    [no_slv];
  int issue_ptr [no_slv];
  int wr_ptr    [no_slv];
  int rd_ptr    [no_slv];

  // Per master lane: requests the vectors send there, and requests seen
  int exp_wr  [no_mst][no_slv];
  int exp_rd  [no_mst][no_slv];
  int aw_seen [no_mst][no_slv];
  int w_seen  [no_mst][no_slv];
  int ar_seen [no_mst][no_slv];
  // Vector index of each write a lane should see, in arrival order
  int lane_wr [no_mst][no_slv][max_vec];

  // Lane model state
  bit        aw_got [no_mst][no_slv];
  bit        w_got  [no_mst][no_slv];
  bit        b_pend [no_mst][no_slv];
  bit        r_pend [no_mst][no_slv];
  bit [31:0] r_data [no_mst][no_slv];

  integer seed;
  int     cycles;
  int     cycle_limit;
  bit     running;

  xbar_unmuxed dut (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .slv_req_i        (slv_req),
    .slv_rsp_o        (slv_rsp),
    .mst_req_o        (mst_req),
    .mst_rsp_i        (mst_rsp),
    .addr_map_i       (addr_map),
    .en_default_mst_i (en_default),
    .default_mst_i    (default_mst)
  );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Read data signature of lane (j, i)
  function automatic logic [31:0] lane_tag(input int j, input int i);
    return 32'((j + 1) << 28) + 32'(i);
  endfunction

  // Ready about three cycles out of four
  function automatic logic ready_draw();
    return ($random(seed) & 3) != 0;
  endfunction

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int p = 0; p < no_slv; p++) begin
      if (issue_ptr[p] < port_cnt[p] || wr_ptr[p] < wr_cnt[p] || rd_ptr[p] < rd_cnt[p]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          rc;
    int          p;
    int          f_port;
    int          f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    int          f_lane;
    int          f_resp;
    logic [31:0] f_rdata;
    string       line;
    n_vec = 0;
    fd = $fopen("test/xbar_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the vector file test/xbar_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        // Comment and blank lines scan fewer than seven fields
        rc = $sscanf(line, "%h %h %h %h %h %h %h",
                     f_port, f_op, f_addr, f_wdata, f_lane, f_resp, f_rdata);
        if (rc == 7 && n_vec < max_vec) begin
          vec_port[n_vec]  = f_port;
          vec_op[n_vec]    = f_op;
          vec_addr[n_vec]  = f_addr;
          vec_wdata[n_vec] = f_wdata;
          vec_lane[n_vec]  = f_lane;
          vec_resp[n_vec]  = f_resp;
          vec_rdata[n_vec] = f_rdata;
          n_vec = n_vec + 1;
        end
      end
      $fclose(fd);
    end

    // Split into per-port queues and per-lane request counts
    for (int k = 0; k < n_vec; k++) begin
      p = vec_port[k];
      port_list[p][port_cnt[p]] = k;
      port_cnt[p] = port_cnt[p] + 1;
      if (vec_op[k] == 0) begin
        wr_list[p][wr_cnt[p]] = k;
        wr_cnt[p] = wr_cnt[p] + 1;
        if (vec_lane[k] != 3) begin
          lane_wr[vec_lane[k]][p][exp_wr[vec_lane[k]][p]] = k;
          exp_wr[vec_lane[k]][p] = exp_wr[vec_lane[k]][p] + 1;
        end
      end else begin
        rd_list[p][rd_cnt[p]] = k;
        rd_cnt[p] = rd_cnt[p] + 1;
        if (vec_lane[k] != 3) begin
          exp_rd[vec_lane[k]][p] = exp_rd[vec_lane[k]][p] + 1;
        end
      end
    end
  endtask

  // Request driver, each port issues its vectors in file order
  always @(posedge clk_i) begin
    int   k;
    logic aw_wait;
    logic w_wait;
    logic ar_wait;
    if (running) begin
      for (int p = 0; p < no_slv; p++) begin
        slv_req[p].b_ready <= 1'b1;
        slv_req[p].r_ready <= 1'b1;
        // A channel keeps valid until its own handshake
        aw_wait = slv_req[p].aw_valid && !slv_rsp[p].aw_ready;
        w_wait  = slv_req[p].w_valid && !slv_rsp[p].w_ready;
        ar_wait = slv_req[p].ar_valid && !slv_rsp[p].ar_ready;
        if (!aw_wait) begin
          slv_req[p].aw_valid <= 1'b0;
        end
        if (!w_wait) begin
          slv_req[p].w_valid <= 1'b0;
        end
        if (!ar_wait) begin
          slv_req[p].ar_valid <= 1'b0;
        end
        // Next vector once every channel of the last one is through
        if (!aw_wait && !w_wait && !ar_wait && issue_ptr[p] < port_cnt[p]) begin
          k = port_list[p][issue_ptr[p]];
          issue_ptr[p] = issue_ptr[p] + 1;
          if (vec_op[k] == 0) begin
            // AW and W go out together
            slv_req[p].aw.addr  <= vec_addr[k];
            slv_req[p].w.data   <= vec_wdata[k];
            slv_req[p].w.strb   <= '1;
            slv_req[p].aw_valid <= 1'b1;
            slv_req[p].w_valid  <= 1'b1;
          end else begin
            slv_req[p].ar.addr  <= vec_addr[k];
            slv_req[p].ar_valid <= 1'b1;
          end
        end
      end
    end
  end

  // Response checker, responses must come back in issue order
  always @(posedge clk_i) begin
    int k;
    if (running) begin
      for (int p = 0; p < no_slv; p++) begin
        if (slv_rsp[p].b_valid && slv_req[p].b_ready) begin
          if (wr_ptr[p] >= wr_cnt[p]) begin
            abort_run($sformatf("slave port %0d gave a write response with no write pending", p));
          end else begin
            k = wr_list[p][wr_ptr[p]];
            check($sformatf("slv_rsp[%0d].b.resp", p), 32'(slv_rsp[p].b.resp), 32'(vec_resp[k]));
            wr_ptr[p] = wr_ptr[p] + 1;
          end
        end
        if (slv_rsp[p].r_valid && slv_req[p].r_ready) begin
          if (rd_ptr[p] >= rd_cnt[p]) begin
            abort_run($sformatf("slave port %0d gave a read response with no read pending", p));
          end else begin
            k = rd_list[p][rd_ptr[p]];
            check($sformatf("slv_rsp[%0d].r.resp", p), 32'(slv_rsp[p].r.resp), 32'(vec_resp[k]));
            check($sformatf("slv_rsp[%0d].r.data", p), slv_rsp[p].r.data, vec_rdata[k]);
            rd_ptr[p] = rd_ptr[p] + 1;
          end
        end
      end
    end
  end

  // Lane models with random ready stalls, OKAY on every access
  always @(posedge clk_i) begin
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;
    for (int j = 0; j < no_mst; j++) begin
      for (int i = 0; i < no_slv; i++) begin
        aw_hs = mst_req[j][i].aw_valid && mst_rsp[j][i].aw_ready;
        w_hs  = mst_req[j][i].w_valid && mst_rsp[j][i].w_ready;
        b_hs  = mst_rsp[j][i].b_valid && mst_req[j][i].b_ready;
        ar_hs = mst_req[j][i].ar_valid && mst_rsp[j][i].ar_ready;
        r_hs  = mst_rsp[j][i].r_valid && mst_req[j][i].r_ready;

        // More requests than the vectors send here means misrouting
        if ((mst_req[j][i].aw_valid && aw_seen[j][i] >= exp_wr[j][i]) ||
            (mst_req[j][i].w_valid && w_seen[j][i] >= exp_wr[j][i]) ||
            (mst_req[j][i].ar_valid && ar_seen[j][i] >= exp_rd[j][i])) begin
          abort_run($sformatf("request on unexpected lane, master %0d slave %0d", j, i));
        end

        if (b_hs) begin
          b_pend[j][i] = 1'b0;
        end
        if (r_hs) begin
          r_pend[j][i] = 1'b0;
        end
        if (aw_hs) begin
          check($sformatf("mst_req[%0d][%0d].aw.addr", j, i), mst_req[j][i].aw.addr,
                vec_addr[lane_wr[j][i][aw_seen[j][i]]]);
          aw_seen[j][i] = aw_seen[j][i] + 1;
          aw_got[j][i]  = 1'b1;
        end
        if (w_hs) begin
          check($sformatf("mst_req[%0d][%0d].w.data", j, i), mst_req[j][i].w.data,
                vec_wdata[lane_wr[j][i][w_seen[j][i]]]);
          check($sformatf("mst_req[%0d][%0d].w.strb", j, i), 32'(mst_req[j][i].w.strb), 32'hf);
          w_seen[j][i] = w_seen[j][i] + 1;
          w_got[j][i]  = 1'b1;
        end
        // Address and data both in, one write response
        if (aw_got[j][i] && w_got[j][i] && !b_pend[j][i]) begin
          b_pend[j][i] = 1'b1;
          aw_got[j][i] = 1'b0;
          w_got[j][i]  = 1'b0;
        end
        if (ar_hs) begin
          ar_seen[j][i] = ar_seen[j][i] + 1;
          r_pend[j][i]  = 1'b1;
          r_data[j][i]  = mst_req[j][i].ar.addr ^ lane_tag(j, i);
        end

        mst_rsp[j][i].aw_ready <= !aw_got[j][i] && ready_draw();
        mst_rsp[j][i].w_ready  <= !w_got[j][i] && ready_draw();
        mst_rsp[j][i].b.resp   <= RESP_OKAY;
        mst_rsp[j][i].b_valid  <= b_pend[j][i];
        mst_rsp[j][i].ar_ready <= !r_pend[j][i] && ready_draw();
        mst_rsp[j][i].r.data   <= r_data[j][i];
        mst_rsp[j][i].r.resp   <= RESP_OKAY;
        mst_rsp[j][i].r_valid  <= r_pend[j][i];
      end
    end
  end

  // Run limit scales with the number of vectors
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles with responses still missing", cycles));
    end
  end

  initial begin
    seed        = 32'h325b;
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    slv_req     = '0;
    mst_rsp     = '0;
    running     = 1'b0;
    cycles      = 0;

    // Rule 3 overlaps rule 0 and never wins
    addr_map[0] = '{idx: 2'd0, start_addr: 32'h0000_0000, end_addr: 32'h1000_0000};
    addr_map[1] = '{idx: 2'd1, start_addr: 32'h1000_0000, end_addr: 32'h2000_0000};
    addr_map[2] = '{idx: 2'd2, start_addr: 32'h2000_0000, end_addr: 32'h3000_0000};
    addr_map[3] = '{idx: 2'd1, start_addr: 32'h0000_8000, end_addr: 32'h0001_0000};
    // Slave 0 has no default port, slave 1 falls back to master 1
    en_default     = 2'b10;
    default_mst[0] = 2'd0;
    default_mst[1] = 2'd1;

    load_vectors();
    cycle_limit = 16 + 200 * n_vec;

    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    // Idle outputs straight after reset
    for (int p = 0; p < no_slv; p++) begin
      check($sformatf("slv_rsp[%0d].b_valid", p), 32'(slv_rsp[p].b_valid), 32'd0);
      check($sformatf("slv_rsp[%0d].r_valid", p), 32'(slv_rsp[p].r_valid), 32'd0);
    end
    for (int j = 0; j < no_mst; j++) begin
      for (int i = 0; i < no_slv; i++) begin
        check($sformatf("mst_req[%0d][%0d].aw_valid", j, i), 32'(mst_req[j][i].aw_valid), 32'd0);
        check($sformatf("mst_req[%0d][%0d].w_valid", j, i), 32'(mst_req[j][i].w_valid), 32'd0);
        check($sformatf("mst_req[%0d][%0d].ar_valid", j, i), 32'(mst_req[j][i].ar_valid), 32'd0);
      end
    end

    running <= 1'b1;
    while (!all_done()) begin
      @(posedge clk_i);
    end
    // A few idle cycles so a stray request still shows up
    repeat (4) @(posedge clk_i);

    for (int j = 0; j < no_mst; j++) begin
      for (int i = 0; i < no_slv; i++) begin
        check($sformatf("lane %0d/%0d aw count", j, i), 32'(aw_seen[j][i]), 32'(exp_wr[j][i]));
        check($sformatf("lane %0d/%0d w count", j, i), 32'(w_seen[j][i]), 32'(exp_wr[j][i]));
        check($sformatf("lane %0d/%0d ar count", j, i), 32'(ar_seen[j][i]), 32'(exp_rd[j][i]));
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

/* test/xbar_vectors.txt */
# port op(0 write, 1 read) addr wdata lane(3 no master lane) resp rdata, all hex
# rdata of a lane read is addr xor ((master+1)<<28 + port)
0 0 00000100 a5a5a5a5 0 0 00000000
0 1 00000100 00000000 0 0 10000100
0 0 10000200 11112222 1 0 00000000
0 1 10000200 00000000 1 0 30000200
0 0 20000300 33334444 2 0 00000000
0 1 20000300 00000000 2 0 10000300
0 1 00008010 00000000 0 0 10008010
0 1 40000000 00000000 3 3 00000000
0 0 50000000 deadbeef 3 3 00000000
0 1 0fff0000 00000000 0 0 1fff0000
0 1 1abc0000 00000000 1 0 3abc0000
0 1 2def0004 00000000 2 0 1def0004
0 1 00000044 00000000 0 0 10000044
0 1 1000000c 00000000 1 0 3000000c
0 1 2000fff0 00000000 2 0 1000fff0
1 0 00000400 01020304 0 0 00000000
1 1 00000400 00000000 0 0 10000401
1 1 18000000 00000000 1 0 38000001
1 0 18000010 55aa55aa 1 0 00000000
1 1 20000000 00000000 3 3 00000000
1 0 2fff0000 77778888 3 3 00000000
1 1 60000000 00000000 1 0 40000001
1 0 70000000 12345678 1 0 00000000
1 1 00000008 00000000 0 0 10000009
1 1 10000010 00000000 1 0 30000011
